// File: vlog.f
+incdir+include
rtl/emu_cfg_pkg.sv
rtl/emu_traffic_pkg.sv
rtl/pattern_ram.sv
rtl/ram_read_arbiter.sv
rtl/start_delay_gen.sv
rtl/pattern_sequencer.sv
rtl/packet_injector.sv
rtl/traffic_statistics.sv
rtl/traffic_emulator_top.sv
sim/traffic_emulator_chk.sv
sim/traffic_emulator_tb.sv

// File: sim/traffic_emulator_tb.sv
`include "emu_consts.svh"

module traffic_emulator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import emu_cfg_pkg::*;
    import emu_traffic_pkg::*;

    localparam int NE    = `EMU_NE;
    localparam int WORDS = 1 << `EMU_ADDR_W;
    localparam int NENT  = 12;
    localparam int MAXH  = 64;   // head slots per endpoint

    typedef struct packed {
        logic [`EMU_NE_W-1:0]      ep;
        logic [`EMU_ROW_W-1:0]     row;
        logic [`EMU_PCK_CNT_W-1:0] num;
        logic [`EMU_RATIO_W-1:0]   ratio;
        logic [2:0]                flits;   // 1 to 4 flits per packet
        logic [`EMU_NE_W-1:0]      dest;
        logic [`EMU_CLASS_W-1:0]   cls;
        logic                      last;
    } tab_row_t;

    // columns are ep, row, packets, ratio, flits, dest, class and last
    // each region listed in row order
    tab_row_t tab [NENT] = '{
        '{0, 1, 2, 100, 1, 1, 0, 0}, '{0, 2, 1, 50, 4, 0, 1, 0}, '{0, 3, 3, 50, 2, 2, 2, 1},
        '{1, 1, 0, 100, 2, 0, 0, 0}, '{1, 2, 2, 25, 4, 3, 3, 0}, '{1, 3, 1, 100, 3, 0, 1, 1},
        '{2, 1, 1, 50, 3, 3, 1, 0},  '{2, 2, 2, 100, 1, 2, 0, 1},
        '{3, 1, 1, 25, 1, 0, 2, 0},  '{3, 2, 2, 50, 4, 1, 0, 0},
        '{3, 3, 1, 100, 2, 3, 3, 0}, '{3, 4, 2, 25, 3, 2, 1, 1}
    };
    int rep_cnt [NE] = '{1, 0, 2, 0};

    logic clk;
    logic reset;
    logic start;
    host_wr_t host_wr;
    logic [`EMU_DATA_W-1:0] host_rd_data;
    logic [`EMU_NE_W-1:0] stat_ep;
    stat_sel_t stat_sel;
    logic [`EMU_STAT_W-1:0] stat_data;
    flit_t flits [NE];
    logic done;

    logic [`EMU_DATA_W-1:0] image [WORDS];
    logic [3:0] exp_head [NE][MAXH];   // {dest, class} in expected order
    int exp_pck [NE];
    int exp_flit [NE];
    int exp_heads [NE];
    int mon_pck [NE];
    int mon_flit [NE];
    int head_cnt [NE];
    int errors;
    int checks;
    int cycles;
    int limit;

    traffic_emulator_top dut0 (
        .clk(clk), .reset(reset), .host_wr_i(host_wr), .host_rd_data_o(host_rd_data),
        .start_i(start), .stat_ep_i(stat_ep), .stat_sel_i(stat_sel),
        .stat_data_o(stat_data), .flits_o(flits), .done_o(done)
    );

    bind traffic_emulator_top traffic_emulator_chk u_chk (
        .clk(clk), .reset(reset), .done_i(done_o), .flits_i(flits_o)
    );

    always #50 clk = ~clk;

    task automatic log_error(string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic compare(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got == exp) else log_error($sformatf("%s: got %0h, expected %0h", what, got, exp));
    endtask

    function automatic logic [`EMU_DATA_W-1:0] entry_word(tab_row_t t);
        pattern_word_u u;
        u = '0;
        u.entry.pck_num   = t.num;
        u.entry.ratio     = t.ratio;
        u.entry.pck_size  = `EMU_PCK_SIZ_W'(t.flits - 1);   // field holds flits minus one
        u.entry.dest      = t.dest;
        u.entry.pck_class = t.cls;
        u.entry.last      = t.last;
        return u;
    endfunction

    function automatic logic [`EMU_DATA_W-1:0] rep_word(int r);
        pattern_word_u u;
        u = '0;
        u.rep.rep_count = r;
        return u;
    endfunction

    // memory image, expected counts, head order and run limit
    task automatic build_expected();
        int minr;
        int maxf;
        minr = `EMU_MAX_RATIO;
        maxf = 0;
        for (int a = 0; a < WORDS; a++) begin
            image[a] = {8{`EMU_ADDR_W'(a)}};   // unused rows
        end
        for (int k = 0; k < NE; k++) begin
            image[k << `EMU_ROW_W] = rep_word(rep_cnt[k]);
        end
        for (int i = 0; i < NENT; i++) begin
            image[{tab[i].ep, tab[i].row}] = entry_word(tab[i]);
        end
        for (int k = 0; k < NE; k++) begin
            exp_pck[k] = 0;
            exp_flit[k] = 0;
            exp_heads[k] = 0;
            mon_pck[k] = 0;
            mon_flit[k] = 0;
            head_cnt[k] = 0;
            for (int p = 0; p <= rep_cnt[k]; p++) begin
                for (int i = 0; i < NENT; i++) begin
                    if (tab[i].ep == k && tab[i].dest != k && tab[i].num != 0) begin
                        exp_pck[k] += tab[i].num;
                        exp_flit[k] += tab[i].num * tab[i].flits;
                        minr = (tab[i].ratio < minr) ? tab[i].ratio : minr;
                        for (int n = 0; n < tab[i].num; n++) begin
                            exp_head[k][exp_heads[k]] = {tab[i].dest, tab[i].cls};
                            exp_heads[k]++;
                        end
                    end
                end
            end
            maxf = (exp_flit[k] > maxf) ? exp_flit[k] : maxf;
        end
        limit = 4 * maxf * `EMU_MAX_RATIO / minr + 500;
    endtask

    task automatic check_stat(int k, stat_sel_t sel, int exp, int seen);
        @(negedge clk);
        stat_ep = k;
        stat_sel = sel;
        @(negedge clk);
        compare($sformatf("ep %0d stat %s", k, sel.name()), stat_data, exp);
        compare($sformatf("ep %0d stat %s vs flits_o", k, sel.name()), stat_data, seen);
    endtask

    // flit monitor sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            for (int k = 0; k < NE; k++) begin
                if (flits[k].valid) begin
                    mon_flit[k]++;
                    assert (!done) else log_error($sformatf("ep %0d flit after done_o", k));
                    if (flits[k].tail) begin
                        mon_pck[k]++;
                    end
                    if (flits[k].head) begin
                        assert (flits[k].dest != `EMU_NE_W'(k))
                            else log_error($sformatf("ep %0d packet to itself", k));
                        assert (head_cnt[k] < exp_heads[k])
                            else log_error($sformatf("ep %0d extra packet", k));
                        if (head_cnt[k] < exp_heads[k]) begin
                            compare($sformatf("ep %0d head %0d dest/class", k, head_cnt[k]),
                                    {flits[k].dest, flits[k].pck_class}, exp_head[k][head_cnt[k]]);
                        end
                        head_cnt[k]++;
                    end
                end
            end
        end
    end

    // slack in the bound covers table load, readback and stat reads
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        host_wr = '0;
        stat_ep = '0;
        stat_sel = STAT_PACKETS;
        errors = 0;
        checks = 0;
        cycles = 0;
        build_expected();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int a = 0; a < WORDS; a++) begin
            @(negedge clk);
            host_wr.we = 1'b1;
            host_wr.addr = a;
            host_wr.data = image[a];
        end
        for (int a = 0; a < WORDS; a++) begin
            @(negedge clk);
            host_wr.we = 1'b0;
            host_wr.addr = a;
            @(negedge clk);   // registered read
            compare($sformatf("readback word %0d", a), host_rd_data, image[a]);
        end

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
        repeat (20) @(negedge clk);   // watch for late flits

        for (int k = 0; k < NE; k++) begin
            check_stat(k, STAT_PACKETS, exp_pck[k], mon_pck[k]);
            check_stat(k, STAT_FLITS, exp_flit[k], mon_flit[k]);
            compare($sformatf("ep %0d head count", k), head_cnt[k], exp_heads[k]);
        end

        // second start must leave every sequencer in its finished state
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (`EMU_START_DELAY + NE * `EMU_START_GAP + 20) begin
            @(negedge clk);
            assert (done) else log_error("done_o dropped after second start");
        end
        for (int k = 0; k < NE; k++) begin
            check_stat(k, STAT_PACKETS, exp_pck[k], mon_pck[k]);
            check_stat(k, STAT_FLITS, exp_flit[k], mon_flit[k]);
        end

        errors += dut0.u_chk.fail_cnt;   // bound assertion failures
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim/traffic_emulator_chk.sv
`include "emu_consts.svh"

module traffic_emulator_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   done_i,
    input emu_traffic_pkg::flit_t flits_i [`EMU_NE]
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`EMU_NE-1:0] open_pck;   // head seen and tail still due
    int                 fail_cnt = 0;   // assertion failures so far

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            open_pck <= '0;
        end else begin
            for (int k = 0; k < `EMU_NE; k++) begin
                if (flits_i[k].valid && flits_i[k].tail) begin
                    open_pck[k] <= 1'b0;
                end else if (flits_i[k].valid && flits_i[k].head) begin
                    open_pck[k] <= 1'b1;
                end
            end
        end
    end

    done_hold: assert property (@(posedge clk) disable iff (reset) !$fell(done_i))
        else begin
            fail_cnt++;
            $error("done_o fell while reset was low");
        end

    for (genvar k = 0; k < `EMU_NE; k++) begin : g_ep
        tail_valid: assert property (@(posedge clk) flits_i[k].tail |-> flits_i[k].valid)
            else begin
                fail_cnt++;
                $error("endpoint %0d: tail set without valid", k);
            end
        head_closed: assert property (@(posedge clk) disable iff (reset)
            flits_i[k].valid && flits_i[k].head |-> !open_pck[k])
            else begin
                fail_cnt++;
                $error("endpoint %0d: second head before a tail", k);
            end
        tail_open: assert property (@(posedge clk) disable iff (reset)
            flits_i[k].valid && flits_i[k].tail && !flits_i[k].head |-> open_pck[k])
            else begin
                fail_cnt++;
                $error("endpoint %0d: tail without a head", k);
            end
        quiet_reset: assert property (@(posedge clk) reset |-> !flits_i[k].valid)
            else begin
                fail_cnt++;
                $error("endpoint %0d: valid flit during reset", k);
            end
    end

endmodule

// File: rtl/traffic_emulator_top.sv
`include "emu_consts.svh"

module traffic_emulator_top (
    input  logic                       clk,
    input  logic                       reset,
    input  emu_cfg_pkg::host_wr_t      host_wr_i,
    output logic [`EMU_DATA_W-1:0]     host_rd_data_o,
    input  logic                       start_i,
    input  logic [`EMU_NE_W-1:0]       stat_ep_i,
    input  emu_traffic_pkg::stat_sel_t stat_sel_i,
    output logic [`EMU_STAT_W-1:0]     stat_data_o,
    output emu_traffic_pkg::flit_t     flits_o [`EMU_NE],
    output logic                       done_o
);

    import emu_cfg_pkg::*;
    import emu_traffic_pkg::*;

    logic [`EMU_NE-1:0]     rd_req;
    logic [`EMU_ROW_W-1:0]  rd_row [`EMU_NE];
    logic [`EMU_NE-1:0]     rd_gnt;
    logic [`EMU_NE-1:0]     rd_valid;
    pattern_word_u          rd_data;    // shared, qualified by rd_valid
    logic [`EMU_ADDR_W-1:0] ram_addr;
    logic [`EMU_DATA_W-1:0] ram_q;
    logic [`EMU_NE-1:0]     ep_start;
    logic [`EMU_NE-1:0]     ep_done;
    inject_cmd_t            cmd [`EMU_NE];
    logic [`EMU_NE-1:0]     cmd_done;

    assign done_o = &ep_done;

    pattern_ram u_ram (
        .clk(clk), .a_addr_i(host_wr_i.addr), .a_data_i(host_wr_i.data),
        .a_we_i(host_wr_i.we), .a_q_o(host_rd_data_o), .b_addr_i(ram_addr), .b_q_o(ram_q)
    );

    ram_read_arbiter u_arb (
        .clk(clk), .reset(reset), .req_i(rd_req), .row_i(rd_row), .gnt_o(rd_gnt),
        .rd_valid_o(rd_valid), .rd_data_o(rd_data), .ram_addr_o(ram_addr), .ram_q_i(ram_q)
    );

    start_delay_gen u_start (.clk(clk), .reset(reset), .start_i(start_i), .start_o(ep_start));

    for (genvar k = 0; k < `EMU_NE; k++) begin : g_ep
        pattern_sequencer #(.SELF_ID(k)) u_seq (
            .clk(clk), .reset(reset), .start_i(ep_start[k]), .rd_req_o(rd_req[k]),
            .rd_row_o(rd_row[k]), .rd_gnt_i(rd_gnt[k]), .rd_valid_i(rd_valid[k]),
            .rd_data_i(rd_data), .cmd_o(cmd[k]), .cmd_done_i(cmd_done[k]), .done_o(ep_done[k])
        );
        packet_injector u_inj (
            .clk(clk), .reset(reset), .cmd_i(cmd[k]), .cmd_done_o(cmd_done[k]),
            .flit_o(flits_o[k])
        );
    end

    traffic_statistics u_stat (
        .clk(clk), .reset(reset), .flits_i(flits_o), .stat_ep_i(stat_ep_i),
        .stat_sel_i(stat_sel_i), .stat_data_o(stat_data_o)
    );

endmodule

// File: rtl/traffic_statistics.sv
`include "emu_consts.svh"

module traffic_statistics (
    input  logic                       clk,
    input  logic                       reset,
    input  emu_traffic_pkg::flit_t     flits_i [`EMU_NE],
    input  logic [`EMU_NE_W-1:0]       stat_ep_i,
    input  emu_traffic_pkg::stat_sel_t stat_sel_i,
    output logic [`EMU_STAT_W-1:0]     stat_data_o
);

    import emu_traffic_pkg::*;

    logic [`EMU_STAT_W-1:0] pck_cnt  [`EMU_NE];
    logic [`EMU_STAT_W-1:0] flit_cnt [`EMU_NE];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `EMU_NE; k++) begin
                pck_cnt[k]  <= '0;
                flit_cnt[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `EMU_NE; k++) begin
                if (flits_i[k].valid) begin
                    flit_cnt[k] <= flit_cnt[k] + 1'b1;
                end
                if (flits_i[k].valid && flits_i[k].tail) begin
                    pck_cnt[k] <= pck_cnt[k] + 1'b1;   // one per tail
                end
            end
        end
    end

    assign stat_data_o = (stat_sel_i == STAT_FLITS) ? flit_cnt[stat_ep_i] : pck_cnt[stat_ep_i];

endmodule

// File: rtl/packet_injector.sv
`include "emu_consts.svh"

module packet_injector (
    input  logic                         clk,
    input  logic                         reset,
    input  emu_traffic_pkg::inject_cmd_t cmd_i,
    output logic                         cmd_done_o,
    output emu_traffic_pkg::flit_t       flit_o
);

    // wide enough for the credit built up over a whole command
    localparam int ACC_W = $clog2(`EMU_MAX_RATIO) + `EMU_PCK_SIZ_W + `EMU_PCK_CNT_W + 1;
    localparam logic [ACC_W-1:0] MAX_ACC = `EMU_MAX_RATIO;

    logic                      active;
    logic                      in_pck;    // body flits still to send
    logic [ACC_W-1:0]          acc;
    logic [`EMU_PCK_CNT_W-1:0] pck_left;
    logic [`EMU_PCK_SIZ_W-1:0] flit_left;
    logic [`EMU_RATIO_W-1:0]   ratio_q;
    logic [`EMU_PCK_SIZ_W-1:0] size_q;
    logic [`EMU_NE_W-1:0]      dest_q;
    logic [`EMU_CLASS_W-1:0]   class_q;
    logic                      pck_start;
    logic                      tail_now;

    assign pck_start = active && !in_pck && (acc >= MAX_ACC);
    assign tail_now  = (pck_start && size_q == '0) || (in_pck && flit_left == 1'b1);

    always_ff @(posedge clk) begin
        if (cmd_i.valid && !active) begin
            ratio_q <= cmd_i.ratio;
            size_q  <= cmd_i.pck_size;
            dest_q  <= cmd_i.dest;
            class_q <= cmd_i.pck_class;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            in_pck     <= 1'b0;
            acc        <= '0;
            pck_left   <= '0;
            flit_left  <= '0;
            flit_o     <= '0;
            cmd_done_o <= 1'b0;
        end else begin
            cmd_done_o   <= 1'b0;
            flit_o.valid <= 1'b0;
            flit_o.head  <= 1'b0;
            flit_o.tail  <= 1'b0;
            if (cmd_i.valid && !active) begin
                active   <= 1'b1;
                acc      <= '0;
                pck_left <= cmd_i.pck_num;
            end else if (active) begin
                acc <= acc + ACC_W'(ratio_q) - (pck_start ? MAX_ACC : '0);
                if (pck_start) begin
                    in_pck    <= (size_q != '0);
                    flit_left <= size_q;
                end else if (in_pck) begin
                    flit_left <= flit_left - 1'b1;
                    in_pck    <= (flit_left != 1'b1);
                end
                if (pck_start || in_pck) begin
                    flit_o.valid     <= 1'b1;
                    flit_o.head      <= pck_start;
                    flit_o.tail      <= tail_now;
                    flit_o.dest      <= dest_q;
                    flit_o.pck_class <= class_q;
                end
                if (tail_now) begin
                    pck_left <= pck_left - 1'b1;
                    if (pck_left == 1'b1) begin
                        active     <= 1'b0;
                        cmd_done_o <= 1'b1;   // lines up with the final tail
                    end
                end
            end
        end
    end

endmodule

// File: rtl/pattern_sequencer.sv
`include "emu_consts.svh"

module pattern_sequencer #(
    parameter int SELF_ID = 0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start_i,
    output logic                         rd_req_o,
    output logic [`EMU_ROW_W-1:0]        rd_row_o,
    input  logic                         rd_gnt_i,
    input  logic                         rd_valid_i,
    input  emu_cfg_pkg::pattern_word_u   rd_data_i,
    output emu_traffic_pkg::inject_cmd_t cmd_o,
    input  logic                         cmd_done_i,
    output logic                         done_o
);

    import emu_cfg_pkg::*;

    localparam int NE_W = `EMU_NE_W;

    typedef enum logic [2:0] {IDLE, LOAD_REPEAT, FETCH, SEND, DONE} seq_state_t;

    seq_state_t     state;
    pattern_entry_t entry;
    logic [REP_W-1:0] rep_left;   // passes still to go after this one
    logic           last_q;
    logic           entry_last;
    logic           skip;
    logic           advance;
    logic           adv_last;

    assign entry      = rd_data_i.entry;
    assign entry_last = entry.last || (rd_row_o == '1);   // region end acts as last
    assign skip       = (entry.dest == NE_W'(SELF_ID)) || (entry.pck_num == '0);
    assign advance    = (state == FETCH && rd_valid_i && skip) ||
                        (state == SEND && cmd_done_i);
    assign adv_last   = (state == SEND) ? last_q : entry_last;
    assign done_o     = (state == DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            rd_req_o <= 1'b0;
            rd_row_o <= '0;
            rep_left <= '0;
            last_q   <= 1'b0;
            cmd_o    <= '0;
        end else begin
            cmd_o.valid <= 1'b0;
            if (rd_gnt_i) begin
                rd_req_o <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start_i) begin
                        rd_row_o <= '0;   // repeat word first
                        rd_req_o <= 1'b1;
                        state    <= LOAD_REPEAT;
                    end
                end
                LOAD_REPEAT: begin
                    if (rd_valid_i) begin
                        rep_left <= rd_data_i.rep.rep_count;
                        rd_row_o <= `EMU_ROW_W'(1);
                        rd_req_o <= 1'b1;
                        state    <= FETCH;
                    end
                end
                FETCH: begin
                    if (rd_valid_i && !skip) begin
                        cmd_o.valid     <= 1'b1;
                        cmd_o.pck_num   <= entry.pck_num;
                        cmd_o.ratio     <= entry.ratio;
                        cmd_o.pck_size  <= entry.pck_size;
                        cmd_o.dest      <= entry.dest;
                        cmd_o.pck_class <= entry.pck_class;
                        last_q          <= entry_last;
                        state           <= SEND;
                    end
                end
                default: begin
                end
            endcase
            // next row, wrap to row 1, or finish
            if (advance) begin
                if (adv_last && rep_left == '0) begin
                    state <= DONE;
                end else begin
                    rd_req_o <= 1'b1;
                    state    <= FETCH;
                    if (adv_last) begin
                        rep_left <= rep_left - 1'b1;
                        rd_row_o <= `EMU_ROW_W'(1);
                    end else begin
                        rd_row_o <= rd_row_o + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/start_delay_gen.sv
`include "emu_consts.svh"

module start_delay_gen (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_i,
    output logic [`EMU_NE-1:0] start_o
);

    localparam int LAST  = `EMU_START_DELAY + (`EMU_NE - 1) * `EMU_START_GAP;
    localparam int CNT_W = $clog2(LAST + 1);

    logic [CNT_W-1:0] cnt;   // cycles since start_i, zero when idle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (start_i) begin
            cnt <= CNT_W'(1);
        end else if (cnt != '0 && cnt < CNT_W'(LAST)) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    // one tap per endpoint, spaced by the start gap
    always_comb begin
        for (int k = 0; k < `EMU_NE; k++) begin
            start_o[k] = (cnt == CNT_W'(`EMU_START_DELAY + k * `EMU_START_GAP));
        end
    end

endmodule

// File: rtl/ram_read_arbiter.sv
`include "emu_consts.svh"

module ram_read_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`EMU_NE-1:0]         req_i,
    input  logic [`EMU_ROW_W-1:0]      row_i [`EMU_NE],
    output logic [`EMU_NE-1:0]         gnt_o,
    output logic [`EMU_NE-1:0]         rd_valid_o,
    output emu_cfg_pkg::pattern_word_u rd_data_o,
    output logic [`EMU_ADDR_W-1:0]     ram_addr_o,
    input  logic [`EMU_DATA_W-1:0]     ram_q_i
);

    localparam int NE   = `EMU_NE;
    localparam int NE_W = `EMU_NE_W;

    logic [NE_W-1:0] ptr;
    logic [NE_W-1:0] gnt_idx;
    logic [NE_W-1:0] pick_idx;
    logic            pick_vld;
    logic [NE-1:0]   eligible;

    // a requester holding its grant this cycle drops req next cycle
    assign eligible = req_i & ~gnt_o;

    always_comb begin
        logic [NE_W-1:0] idx;
        pick_vld = 1'b0;
        pick_idx = ptr;
        for (int i = 0; i < NE; i++) begin
            idx = ptr + NE_W'(i);   // wraps, NE is a power of two
            if (!pick_vld && eligible[idx]) begin
                pick_vld = 1'b1;
                pick_idx = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr        <= '0;
            gnt_o      <= '0;
            gnt_idx    <= '0;
            rd_valid_o <= '0;
        end else begin
            rd_valid_o <= gnt_o;    // ram data lands one cycle after grant
            gnt_o      <= '0;
            if (pick_vld) begin
                gnt_o[pick_idx] <= 1'b1;
                gnt_idx         <= pick_idx;
                ptr             <= pick_idx + 1'b1;
            end
        end
    end

    assign ram_addr_o = {gnt_idx, row_i[gnt_idx]};
    assign rd_data_o  = ram_q_i;

endmodule

// File: rtl/pattern_ram.sv
`include "emu_consts.svh"

module pattern_ram (
    input  logic                   clk,
    // port a, host side
    input  logic [`EMU_ADDR_W-1:0] a_addr_i,
    input  logic [`EMU_DATA_W-1:0] a_data_i,
    input  logic                   a_we_i,
    output logic [`EMU_DATA_W-1:0] a_q_o,
    // port b, read only, arbiter side
    input  logic [`EMU_ADDR_W-1:0] b_addr_i,
    output logic [`EMU_DATA_W-1:0] b_q_o
);

    localparam int DEPTH = 1 << `EMU_ADDR_W;

    logic [`EMU_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_data_i;
        end
        a_q_o <= mem[a_addr_i];   // old data on a write cycle
    end

    always_ff @(posedge clk) begin
        b_q_o <= mem[b_addr_i];
    end

endmodule

// File: rtl/emu_traffic_pkg.sv
`include "emu_consts.svh"

package emu_traffic_pkg;

    typedef struct packed {
        logic                     valid;
        logic                     head;
        logic                     tail;
        logic [`EMU_NE_W-1:0]     dest;
        logic [`EMU_CLASS_W-1:0]  pck_class;
    } flit_t;

    // one pattern entry handed from sequencer to injector
    typedef struct packed {
        logic                      valid;
        logic [`EMU_PCK_CNT_W-1:0] pck_num;
        logic [`EMU_RATIO_W-1:0]   ratio;
        logic [`EMU_PCK_SIZ_W-1:0] pck_size;
        logic [`EMU_NE_W-1:0]      dest;
        logic [`EMU_CLASS_W-1:0]   pck_class;
    } inject_cmd_t;

    typedef enum logic {
        STAT_PACKETS,
        STAT_FLITS
    } stat_sel_t;

endpackage

// File: rtl/emu_cfg_pkg.sv
`include "emu_consts.svh"

package emu_cfg_pkg;

    localparam int REP_W = 32;
    localparam int ENTRY_USED_W = `EMU_PCK_CNT_W + `EMU_RATIO_W + `EMU_PCK_SIZ_W
                                + `EMU_NE_W + `EMU_CLASS_W + 1;

    // rows 1 and up of a region
    typedef struct packed {
        logic [`EMU_DATA_W-ENTRY_USED_W-1:0] padding;
        logic [`EMU_PCK_CNT_W-1:0]           pck_num;
        logic [`EMU_RATIO_W-1:0]             ratio;
        logic [`EMU_PCK_SIZ_W-1:0]           pck_size;
        logic [`EMU_NE_W-1:0]                dest;
        logic [`EMU_CLASS_W-1:0]             pck_class;
        logic                                last;       // end of the pattern list
    } pattern_entry_t;

    // row 0 of a region
    typedef struct packed {
        logic [`EMU_DATA_W-REP_W-1:0] padding;
        logic [REP_W-1:0]             rep_count;  // extra passes over the list
    } repeat_word_t;

    typedef union packed {
        pattern_entry_t entry;
        repeat_word_t   rep;
    } pattern_word_u;

    typedef struct packed {
        logic                     we;
        logic [`EMU_ADDR_W-1:0]   addr;
        logic [`EMU_DATA_W-1:0]   data;
    } host_wr_t;

endpackage

// File: include/emu_consts.svh
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

// endpoint geometry
`define EMU_NE          4
`define EMU_NE_W        2

// pattern memory, one region of rows per endpoint
`define EMU_ROW_W       3
`define EMU_ADDR_W      (`EMU_NE_W + `EMU_ROW_W)   // {endpoint, row}
`define EMU_DATA_W      40

// pattern entry fields
`define EMU_PCK_CNT_W   12
`define EMU_RATIO_W     7
`define EMU_PCK_SIZ_W   4      // flits per packet minus one
`define EMU_CLASS_W     2

// pacing and start-up timing
`define EMU_MAX_RATIO   100
`define EMU_START_DELAY 12
`define EMU_START_GAP   2

`define EMU_STAT_W      32

`endif
